/* verilog/dsp_macros.svh */
`ifndef DSP_MACROS_SVH
`define DSP_MACROS_SVH

// Symbols carried in one code word
`define DSP_LANES 4
`define DSP_CODE_W 8

// Feed-forward filter
`define DSP_FFE_TAPS 3
`define DSP_WEIGHT_W 8
`define DSP_ACC_W 18
`define DSP_SHIFT_W 3

// Sequence estimator, current and previous symbol
`define DSP_EST_DEPTH 2
`define DSP_EST_W 8

// Words kept for the filter window and the checker alignment
`define DSP_HIST_DEPTH 3

`endif

/* verilog/dsp_pkg.sv */
`include "dsp_macros.svh"

package dsp_pkg;

	typedef logic signed [`DSP_CODE_W-1:0] code_t;
	typedef logic signed [`DSP_WEIGHT_W-1:0] weight_t;
	typedef logic signed [`DSP_EST_W-1:0] chan_est_t;
	typedef logic [`DSP_SHIFT_W-1:0] shift_t;
	typedef logic signed [`DSP_ACC_W-1:0] acc_t;
	typedef logic [$clog2(`DSP_LANES)-1:0] lane_idx_t;
	typedef logic [$clog2(`DSP_FFE_TAPS)-1:0] cfg_idx_t;	// Wide enough for taps and estimates

	// Lane 0 is the oldest symbol
	typedef struct packed {
		code_t [`DSP_LANES-1:0] sym;
	} code_word_t;

	typedef logic [`DSP_LANES-1:0] bit_word_t;	// 1 is +1, 0 is -1

	typedef enum logic [2:0] {
		CFG_WEIGHT,
		CFG_THRESH,
		CFG_FFE_SHIFT,
		CFG_MLSD_SHIFT,
		CFG_CHAN_EST
	} cfg_target_e;

	typedef struct packed {
		logic we;
		cfg_target_e target;
		lane_idx_t lane;
		cfg_idx_t idx;
		code_t data;
	} cfg_write_t;

	typedef struct packed {
		weight_t [`DSP_FFE_TAPS-1:0][`DSP_LANES-1:0] weights;
		code_t [`DSP_LANES-1:0] thresh;
		shift_t [`DSP_LANES-1:0] ffe_shift;
		shift_t [`DSP_LANES-1:0] mlsd_shift;
		chan_est_t [`DSP_LANES-1:0][`DSP_EST_DEPTH-1:0] chan_est;
	} dsp_cfg_t;

endpackage

/* verilog/code_history.sv */
`timescale 1ns/1ps
`include "dsp_macros.svh"

module code_history (
	input logic clk,
	input logic rstb,
	input dsp_pkg::code_word_t codes_i,
	output dsp_pkg::code_word_t [`DSP_HIST_DEPTH-1:0] hist_o
);

	dsp_pkg::code_word_t [`DSP_HIST_DEPTH-1:0] hist_q;	// Stage 0 is the newest word

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			hist_q <= '0;
		end else begin
			hist_q[0] <= codes_i;
			for (int i = 1; i < `DSP_HIST_DEPTH; i++) begin
				hist_q[i] <= hist_q[i-1];
			end
		end
	end

	// Filter reads stages 0 and 1, the checker reads stage 2 two cycles later
	assign hist_o = hist_q;

endmodule

/* verilog/dsp_config_regs.sv */
`timescale 1ns/1ps
`include "dsp_macros.svh"

module dsp_config_regs (
	input logic clk,
	input logic rstb,
	input dsp_pkg::cfg_write_t cfg_wr_i,
	output dsp_pkg::dsp_cfg_t cfg_o
);

	dsp_pkg::dsp_cfg_t cfg_q;

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			cfg_q <= '0;
		end else if (cfg_wr_i.we) begin
			case (cfg_wr_i.target)
				dsp_pkg::CFG_WEIGHT: begin
					if (cfg_wr_i.idx < `DSP_FFE_TAPS) begin
						cfg_q.weights[cfg_wr_i.idx][cfg_wr_i.lane] <=
							dsp_pkg::weight_t'(cfg_wr_i.data);
					end
				end
				dsp_pkg::CFG_THRESH: cfg_q.thresh[cfg_wr_i.lane] <= cfg_wr_i.data;
				dsp_pkg::CFG_FFE_SHIFT: begin
					cfg_q.ffe_shift[cfg_wr_i.lane] <= cfg_wr_i.data[`DSP_SHIFT_W-1:0];
				end
				dsp_pkg::CFG_MLSD_SHIFT: begin
					cfg_q.mlsd_shift[cfg_wr_i.lane] <= cfg_wr_i.data[`DSP_SHIFT_W-1:0];
				end
				dsp_pkg::CFG_CHAN_EST: begin
					if (cfg_wr_i.idx < `DSP_EST_DEPTH) begin
						cfg_q.chan_est[cfg_wr_i.lane][cfg_wr_i.idx] <=
							dsp_pkg::chan_est_t'(cfg_wr_i.data);
					end
				end
				default: ;	// Unknown target, nothing changes
			endcase
		end
	end

	assign cfg_o = cfg_q;

	// Tap or estimate index must exist for the addressed table
	a_cfg_idx_range: assert property (@(posedge clk) disable iff (!rstb)
		cfg_wr_i.we |->
			!(cfg_wr_i.target == dsp_pkg::CFG_WEIGHT && cfg_wr_i.idx >= `DSP_FFE_TAPS) &&
			!(cfg_wr_i.target == dsp_pkg::CFG_CHAN_EST && cfg_wr_i.idx >= `DSP_EST_DEPTH))
		else $error("config write with index %0d out of range", cfg_wr_i.idx);

endmodule

/* verilog/ffe_datapath.sv */
`timescale 1ns/1ps
`include "dsp_macros.svh"

module ffe_datapath (
	input logic clk,
	input logic rstb,
	input dsp_pkg::code_word_t [1:0] hist_i,
	input dsp_pkg::dsp_cfg_t cfg_i,
	output dsp_pkg::code_word_t eq_o
);

	localparam dsp_pkg::acc_t code_max = dsp_pkg::acc_t'(2**(`DSP_CODE_W-1) - 1);
	localparam dsp_pkg::acc_t code_min = -dsp_pkg::acc_t'(2**(`DSP_CODE_W-1));

	dsp_pkg::code_word_t eq_d;
	dsp_pkg::code_word_t eq_q;

	always_comb begin
		dsp_pkg::code_t win [0:2*`DSP_LANES-1];
		dsp_pkg::acc_t acc;
		dsp_pkg::acc_t prod;
		dsp_pkg::acc_t shifted;
		// Previous word first, so lane l of the new word sits at LANES+l
		for (int j = 0; j < `DSP_LANES; j++) begin
			win[j] = hist_i[1].sym[j];
			win[`DSP_LANES + j] = hist_i[0].sym[j];
		end
		for (int l = 0; l < `DSP_LANES; l++) begin
			acc = '0;
			for (int t = 0; t < `DSP_FFE_TAPS; t++) begin
				prod = $signed(cfg_i.weights[t][l]) * $signed(win[`DSP_LANES + l - t]);
				acc = acc + prod;
			end
			shifted = acc >>> cfg_i.ffe_shift[l];
			if (shifted > code_max) begin
				eq_d.sym[l] = dsp_pkg::code_t'(code_max);
			end else if (shifted < code_min) begin
				eq_d.sym[l] = dsp_pkg::code_t'(code_min);
			end else begin
				eq_d.sym[l] = dsp_pkg::code_t'(shifted);
			end
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			eq_q <= '0;
		end else begin
			eq_q <= eq_d;
		end
	end

	assign eq_o = eq_q;

endmodule

/* verilog/slicer.sv */
`timescale 1ns/1ps
`include "dsp_macros.svh"

module slicer (
	input logic clk,
	input logic rstb,
	input dsp_pkg::code_word_t eq_i,
	input dsp_pkg::dsp_cfg_t cfg_i,
	output dsp_pkg::bit_word_t dec_o,
	output dsp_pkg::bit_word_t dec_prev_o
);

	dsp_pkg::bit_word_t dec_d;
	dsp_pkg::bit_word_t dec_q;
	dsp_pkg::bit_word_t dec_prev_q;	// Predecessor word for checker lane 0

	always_comb begin
		for (int l = 0; l < `DSP_LANES; l++) begin
			dec_d[l] = $signed(eq_i.sym[l]) > $signed(cfg_i.thresh[l]);	// Equal slices to 0
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			dec_q <= '0;
			dec_prev_q <= '0;
		end else begin
			dec_q <= dec_d;
			dec_prev_q <= dec_q;
		end
	end

	assign dec_o = dec_q;
	assign dec_prev_o = dec_prev_q;

endmodule

/* verilog/mlsd_checker.sv */
`timescale 1ns/1ps
`include "dsp_macros.svh"

module mlsd_checker (
	input logic clk,
	input logic rstb,
	input dsp_pkg::code_word_t codes_i,
	input dsp_pkg::bit_word_t dec_i,
	input dsp_pkg::bit_word_t dec_prev_i,
	input dsp_pkg::dsp_cfg_t cfg_i,
	output dsp_pkg::bit_word_t checked_o
);

	dsp_pkg::bit_word_t checked_d;
	dsp_pkg::bit_word_t checked_q;

	always_comb begin
		logic [2*`DSP_LANES-1:0] bit_win;
		logic prev_bit;
		dsp_pkg::acc_t est0;
		dsp_pkg::acc_t est1;
		dsp_pkg::acc_t tail;
		dsp_pkg::acc_t code;
		dsp_pkg::acc_t hyp_one;
		dsp_pkg::acc_t hyp_zero;
		dsp_pkg::acc_t dist_one;
		dsp_pkg::acc_t dist_zero;
		bit_win = {dec_i, dec_prev_i};	// Lane l of dec_i sits at LANES+l
		for (int l = 0; l < `DSP_LANES; l++) begin
			prev_bit = bit_win[`DSP_LANES + l - 1];
			est0 = $signed(cfg_i.chan_est[l][0]);
			est1 = $signed(cfg_i.chan_est[l][1]);
			code = $signed(codes_i.sym[l]);
			tail = prev_bit ? est1 : -est1;	// ISI from the previous symbol
			hyp_one = (est0 + tail) >>> cfg_i.mlsd_shift[l];
			hyp_zero = (tail - est0) >>> cfg_i.mlsd_shift[l];
			dist_one = (code > hyp_one) ? code - hyp_one : hyp_one - code;
			dist_zero = (code > hyp_zero) ? code - hyp_zero : hyp_zero - code;
			if (dist_one < dist_zero) begin
				checked_d[l] = 1'b1;
			end else if (dist_zero < dist_one) begin
				checked_d[l] = 1'b0;
			end else begin
				checked_d[l] = dec_i[l];	// Tie keeps the slicer bit
			end
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			checked_q <= '0;
		end else begin
			checked_q <= checked_d;
		end
	end

	assign checked_o = checked_q;

	// Zero config and cleared slicer give ties on 0 right after reset
	a_checked_after_reset: assert property (@(posedge clk)
		$rose(rstb) |=> checked_o == '0)
		else $error("checked bits not zero after reset release");

endmodule

/* verilog/dsp_backend.sv */
`timescale 1ns/1ps
`include "dsp_macros.svh"

module dsp_backend (
	input logic clk,
	input logic rstb,
	input dsp_pkg::code_word_t codes_i,
	input dsp_pkg::cfg_write_t cfg_wr_i,
	output dsp_pkg::code_word_t estimated_bits_o,
	output dsp_pkg::bit_word_t decided_bits_o,
	output dsp_pkg::bit_word_t checked_bits_o
);

	dsp_pkg::code_word_t [`DSP_HIST_DEPTH-1:0] hist;
	dsp_pkg::dsp_cfg_t cfg;
	dsp_pkg::code_word_t eq_word;
	dsp_pkg::bit_word_t dec_word;
	dsp_pkg::bit_word_t dec_prev;

	code_history hist_i (
		.clk (clk),
		.rstb (rstb),
		.codes_i (codes_i),
		.hist_o (hist)
	);

	dsp_config_regs cfg_regs_i (
		.clk (clk),
		.rstb (rstb),
		.cfg_wr_i (cfg_wr_i),
		.cfg_o (cfg)
	);

	ffe_datapath ffe_i (
		.clk (clk),
		.rstb (rstb),
		.hist_i (hist[1:0]),
		.cfg_i (cfg),
		.eq_o (eq_word)
	);

	slicer slicer_i (
		.clk (clk),
		.rstb (rstb),
		.eq_i (eq_word),
		.cfg_i (cfg),
		.dec_o (dec_word),
		.dec_prev_o (dec_prev)
	);

	// Stage 2 lines the codes up with the slicer output
	mlsd_checker mlsd_i (
		.clk (clk),
		.rstb (rstb),
		.codes_i (hist[2]),
		.dec_i (dec_word),
		.dec_prev_i (dec_prev),
		.cfg_i (cfg),
		.checked_o (checked_bits_o)
	);

	assign estimated_bits_o = eq_word;
	assign decided_bits_o = dec_word;

endmodule

/* tb/tb_dsp_backend.sv */
`timescale 1ns/1ps
`include "dsp_macros.svh"

module tb_dsp_backend;

	localparam int max_cycles = 2000;	// Tests take about 400 cycles
	localparam int code_max = (1 << (`DSP_CODE_W - 1)) - 1;
	localparam int code_min = -(1 << (`DSP_CODE_W - 1));

	logic clk;
	logic rstb;
	dsp_pkg::code_word_t codes;
	dsp_pkg::cfg_write_t cfg_wr;
	dsp_pkg::code_word_t est_word;
	dsp_pkg::bit_word_t dec_bits;
	dsp_pkg::bit_word_t chk_bits;

	int errors = 0;
	int checks = 0;
	int cycles = 0;

	// Model state, all zero like the DUT after reset
	int m_w [`DSP_FFE_TAPS][`DSP_LANES];
	int m_th [`DSP_LANES];
	int m_fsh [`DSP_LANES];
	int m_msh [`DSP_LANES];
	int m_est [`DSP_LANES][`DSP_EST_DEPTH];
	int m_hist [`DSP_HIST_DEPTH][`DSP_LANES];
	int m_eq [`DSP_LANES];
	bit [`DSP_LANES-1:0] m_dec;
	bit [`DSP_LANES-1:0] m_dec_prev;
	bit [`DSP_LANES-1:0] m_chk;

	dsp_backend UUT (
		.clk (clk),
		.rstb (rstb),
		.codes_i (codes),
		.cfg_wr_i (cfg_wr),
		.estimated_bits_o (est_word),
		.decided_bits_o (dec_bits),
		.checked_bits_o (chk_bits)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout: the tests did not finish within %0d cycles", max_cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	function automatic int abs_int(input int v);
		return (v < 0) ? -v : v;
	endfunction

	// Symbol n-t comes from the previous word when it reaches before lane 0
	function automatic int ffe_value(input int lane);
		int sum;
		int src;
		sum = 0;
		for (int t = 0; t < `DSP_FFE_TAPS; t++) begin
			src = lane - t;
			if (src >= 0) sum += m_w[t][lane] * m_hist[0][src];
			else sum += m_w[t][lane] * m_hist[1][src + `DSP_LANES];
		end
		sum = sum >>> m_fsh[lane];
		return (sum > code_max) ? code_max : (sum < code_min) ? code_min : sum;
	endfunction

	function automatic int hypothesis(input int lane, input bit b, input bit prev);
		int sum;
		sum = b ? m_est[lane][0] : -m_est[lane][0];
		sum += prev ? m_est[lane][1] : -m_est[lane][1];
		return sum >>> m_msh[lane];
	endfunction

	task automatic apply_write();
		int data;
		int lane;
		data = $signed(cfg_wr.data);
		lane = cfg_wr.lane;
		case (cfg_wr.target)
			dsp_pkg::CFG_WEIGHT: if (cfg_wr.idx < `DSP_FFE_TAPS) m_w[cfg_wr.idx][lane] = data;
			dsp_pkg::CFG_THRESH: m_th[lane] = data;
			dsp_pkg::CFG_FFE_SHIFT: m_fsh[lane] = data & ((1 << `DSP_SHIFT_W) - 1);
			dsp_pkg::CFG_MLSD_SHIFT: m_msh[lane] = data & ((1 << `DSP_SHIFT_W) - 1);
			dsp_pkg::CFG_CHAN_EST: if (cfg_wr.idx < `DSP_EST_DEPTH) m_est[lane][cfg_wr.idx] = data;
			default: ;
		endcase
	endtask

	// One clock edge of the model, every stage computed from the old state
	task automatic model_tick();
		int new_eq [`DSP_LANES];
		bit [`DSP_LANES-1:0] new_dec;
		bit [`DSP_LANES-1:0] new_chk;
		int d1;
		int d0;
		bit prev;
		for (int l = 0; l < `DSP_LANES; l++) begin
			prev = (l == 0) ? m_dec_prev[`DSP_LANES-1] : m_dec[l-1];
			d1 = abs_int(m_hist[2][l] - hypothesis(l, 1'b1, prev));
			d0 = abs_int(m_hist[2][l] - hypothesis(l, 1'b0, prev));
			new_chk[l] = (d1 < d0) ? 1'b1 : ((d0 < d1) ? 1'b0 : m_dec[l]);
			new_dec[l] = m_eq[l] > m_th[l];
			new_eq[l] = ffe_value(l);
		end
		m_chk = new_chk;
		m_dec_prev = m_dec;
		m_dec = new_dec;
		m_eq = new_eq;
		for (int i = `DSP_HIST_DEPTH - 1; i > 0; i--) m_hist[i] = m_hist[i-1];
		for (int l = 0; l < `DSP_LANES; l++) m_hist[0][l] = $signed(codes.sym[l]);
		if (cfg_wr.we) apply_write();
	endtask

	task automatic check_value(input string name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		assert (actual == expected) else begin
			errors++;
			$display("error %s %s: expected %h actual %h", name, what, expected, actual);
		end
	endtask

	task automatic step(input string name);
		dsp_pkg::code_word_t exp_eq;
		@(posedge clk);
		model_tick();
		#1;
		for (int l = 0; l < `DSP_LANES; l++) exp_eq.sym[l] = dsp_pkg::code_t'(m_eq[l]);
		check_value(name, "estimated", exp_eq, est_word);
		check_value(name, "decided", m_dec, dec_bits);
		check_value(name, "checked", m_chk, chk_bits);
	endtask

	task automatic write_cfg(input string name, input dsp_pkg::cfg_target_e target,
		input int lane, input int idx, input int data);
		cfg_wr.we = 1'b1;
		cfg_wr.target = target;
		cfg_wr.lane = dsp_pkg::lane_idx_t'(lane);
		cfg_wr.idx = dsp_pkg::cfg_idx_t'(idx);
		cfg_wr.data = dsp_pkg::code_t'(data);
		step(name);
		cfg_wr.we = 1'b0;
	endtask

	task automatic write_all_lanes(input string name, input dsp_pkg::cfg_target_e target,
		input int idx, input int data);
		for (int l = 0; l < `DSP_LANES; l++) write_cfg(name, target, l, idx, data);
	endtask

	task automatic random_codes();
		for (int l = 0; l < `DSP_LANES; l++) codes.sym[l] = dsp_pkg::code_t'($urandom);
	endtask

	task automatic fill_codes(input int v);
		for (int l = 0; l < `DSP_LANES; l++) codes.sym[l] = dsp_pkg::code_t'(v);
	endtask

	task automatic reset_test();
		for (int i = 0; i < 20; i++) begin
			random_codes();
			step("reset");
			check_value("reset", "estimated zero", 0, est_word);
			check_value("reset", "decided zero", 0, dec_bits);
			check_value("reset", "checked zero", 0, chk_bits);
		end
	endtask

	task automatic filter_identity_test();
		dsp_pkg::code_word_t last;
		write_all_lanes("filter identity", dsp_pkg::CFG_WEIGHT, 0, 1);
		for (int i = 0; i < 12; i++) begin
			last = codes;
			random_codes();
			step("filter identity");
			if (i > 0) check_value("filter identity", "codes delayed", last, est_word);
		end
	endtask

	task automatic filter_shift_test();
		for (int l = 0; l < `DSP_LANES; l++) begin
			write_cfg("filter shift", dsp_pkg::CFG_WEIGHT, l, 0, 2 + l);
			write_cfg("filter shift", dsp_pkg::CFG_WEIGHT, l, 1, -1);
			write_cfg("filter shift", dsp_pkg::CFG_WEIGHT, l, 2, 3);
			write_cfg("filter shift", dsp_pkg::CFG_FFE_SHIFT, l, 0, 1 + l % 2);
		end
		repeat (12) begin
			random_codes();
			step("filter shift");
		end
		fill_codes(code_max);
		repeat (3) step("filter shift");
		check_value("filter shift", "clip high", {`DSP_LANES{8'h7f}}, est_word);
		fill_codes(code_min);
		repeat (3) step("filter shift");
		check_value("filter shift", "clip low", {`DSP_LANES{8'h80}}, est_word);
	endtask

	task automatic slicer_test();
		int th [`DSP_LANES] = '{-20, 0, 35, -100};
		write_all_lanes("slicer", dsp_pkg::CFG_WEIGHT, 0, 1);
		write_all_lanes("slicer", dsp_pkg::CFG_WEIGHT, 1, 0);
		write_all_lanes("slicer", dsp_pkg::CFG_WEIGHT, 2, 0);
		write_all_lanes("slicer", dsp_pkg::CFG_FFE_SHIFT, 0, 0);
		for (int l = 0; l < `DSP_LANES; l++) write_cfg("slicer", dsp_pkg::CFG_THRESH, l, 0, th[l]);
		for (int off = -1; off <= 1; off++) begin
			for (int l = 0; l < `DSP_LANES; l++) codes.sym[l] = dsp_pkg::code_t'(th[l] + off);
			repeat (3) step("slicer");
			check_value("slicer", "decisions", (off > 0) ? 4'hf : 4'h0, dec_bits);
		end
	endtask

	// Inverting filter makes the slicer disagree with the sign of the code
	task automatic checker_test();
		write_all_lanes("checker", dsp_pkg::CFG_WEIGHT, 0, -1);
		write_all_lanes("checker", dsp_pkg::CFG_THRESH, 0, -1);
		write_all_lanes("checker", dsp_pkg::CFG_CHAN_EST, 0, 40);
		write_all_lanes("checker", dsp_pkg::CFG_CHAN_EST, 1, 0);
		fill_codes(40);
		repeat (5) step("checker");
		check_value("checker", "override to 1", {4'h0, 4'hf}, {dec_bits, chk_bits});
		fill_codes(-40);
		repeat (5) step("checker");
		check_value("checker", "override to 0", {4'hf, 4'h0}, {dec_bits, chk_bits});
		fill_codes(0);
		repeat (5) step("checker");
		check_value("checker", "tie keeps decision", {4'hf, 4'hf}, {dec_bits, chk_bits});
	endtask

	task automatic random_test();
		dsp_pkg::cfg_target_e target;
		int idx;
		for (int i = 0; i < 200; i++) begin
			random_codes();
			if (i == 100) begin
				write_cfg("random", dsp_pkg::CFG_FFE_SHIFT, 2, 0, 3);	// Fixed mid-stream change
			end else if ($urandom % 6 == 0) begin
				target = dsp_pkg::cfg_target_e'($urandom % 5);
				idx = (target == dsp_pkg::CFG_WEIGHT) ? $urandom % `DSP_FFE_TAPS
					: (target == dsp_pkg::CFG_CHAN_EST) ? $urandom % `DSP_EST_DEPTH : 0;
				write_cfg("random", target, $urandom % `DSP_LANES, idx, $urandom);
			end else begin
				step("random");
			end
		end
	endtask

	initial begin
		rstb = 1'b0;
		codes = '0;
		cfg_wr = '0;
		void'($urandom(32'h14af93a7));
		repeat (3) @(posedge clk);
		#1;
		rstb = 1'b1;
		reset_test();
		filter_identity_test();
		filter_shift_test();
		slicer_test();
		checker_test();
		random_test();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* build.f */
+incdir+verilog
verilog/dsp_pkg.sv
verilog/code_history.sv
verilog/dsp_config_regs.sv
verilog/ffe_datapath.sv
verilog/slicer.sv
verilog/mlsd_checker.sv
verilog/dsp_backend.sv
tb/tb_dsp_backend.sv

/* run_sim.sh */
#!/bin/bash
# Compile with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dsp_backend \
	-f build.f -o tb_dsp_backend > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/tb_dsp_backend > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "simulation reported failures"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation clean"
exit 0
